// ==== hw/soc_map_pkg.sv ====
// SoC memory map and target/register encodings.
// L2 holds only L2_WORDS words, so the whole DRAM region aliases onto them.
package soc_map_pkg;

  localparam int unsigned ADDR_W = 64;

  //////////////////////////////////////////////////
  // Memory map
  //////////////////////////////////////////////////

  localparam logic [ADDR_W-1:0] DRAM_BASE = 64'h8000_0000;
  localparam logic [ADDR_W-1:0] DRAM_LEN  = 64'h4000_0000;
  localparam logic [ADDR_W-1:0] UART_BASE = 64'hC000_0000;
  localparam logic [ADDR_W-1:0] UART_LEN  = 64'h1000;
  localparam logic [ADDR_W-1:0] CTRL_BASE = 64'hD000_0000;
  localparam logic [ADDR_W-1:0] CTRL_LEN  = 64'h1000;

  // Word index comes from address bits 12:3
  localparam int unsigned L2_WORDS = 1024;
  localparam int unsigned L2_IDX_W = $clog2(L2_WORDS);

  typedef enum logic [1:0] {
    TGT_L2,
    TGT_UART,
    TGT_CTRL,
    TGT_NONE
  } target_e;

  // Offset bits 5:3, i.e. byte offsets 0x00, 0x08, 0x10, 0x18
  typedef enum logic [2:0] {
    REG_EXIT      = 3'd0,
    REG_HW_CNT_EN = 3'd1,
    REG_DRAM_BASE = 3'd2,
    REG_DRAM_END  = 3'd3
  } ctrl_reg_e;

endpackage

// ==== hw/soc_bus_pkg.sv ====
// Request/response bus and APB types.
// Needs soc_map_pkg compiled first for the address width.
package soc_bus_pkg;

  localparam int unsigned DATA_W     = 64;
  localparam int unsigned STRB_W     = DATA_W / 8;
  localparam int unsigned APB_DATA_W = 32;
  localparam int unsigned APB_ADDR_W = 32;

  typedef struct packed {
    logic                            req;
    logic                            we;
    logic [soc_map_pkg::ADDR_W-1:0]  addr;
    logic [DATA_W-1:0]               wdata;
    logic [STRB_W-1:0]               be;
  } bus_req_t;

  typedef struct packed {
    logic              gnt;
    logic              rvalid;
    logic              err;
    logic [DATA_W-1:0] rdata;
  } bus_rsp_t;

  // Offset is relative to the region base
  typedef struct packed {
    logic                  req;
    logic                  we;
    logic [APB_ADDR_W-1:0] offset;
    logic [DATA_W-1:0]     wdata;
    logic [STRB_W-1:0]     be;
  } tgt_req_t;

  typedef struct packed {
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    logic [APB_DATA_W-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [APB_DATA_W-1:0] prdata;
    logic                  pready;
    logic                  pslverr;
  } apb_rsp_t;

  // Byte-enable merge of write data into an existing word
  function automatic logic [DATA_W-1:0] be_merge(input logic [DATA_W-1:0] old_d,
                                                 input logic [DATA_W-1:0] new_d,
                                                 input logic [STRB_W-1:0] be);
    logic [DATA_W-1:0] res;
    res = old_d;
    for (int b = 0; b < STRB_W; b++) begin
      if (be[b]) res[b*8 +: 8] = new_d[b*8 +: 8];
    end
    return res;
  endfunction

endpackage

// ==== hw/soc_xbar.sv ====
// Single-master router for the req/gnt/rvalid bus.
// Responses arrive exactly one cycle after the grant, so one pending slot is enough.
// Unmapped addresses are granted at once and answered with err.
`timescale 1ns/1ns

module soc_xbar (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  soc_bus_pkg::bus_req_t bus_req_i,
  output soc_bus_pkg::bus_rsp_t bus_rsp_o,
  output soc_bus_pkg::tgt_req_t l2_req_o,
  output soc_bus_pkg::tgt_req_t uart_req_o,
  output soc_bus_pkg::tgt_req_t ctrl_req_o,
  input  soc_bus_pkg::bus_rsp_t l2_rsp_i,
  input  soc_bus_pkg::bus_rsp_t uart_rsp_i,
  input  soc_bus_pkg::bus_rsp_t ctrl_rsp_i
);

  function automatic soc_map_pkg::target_e decode(
    input logic [soc_map_pkg::ADDR_W-1:0] addr
  );
    if (addr >= soc_map_pkg::DRAM_BASE &&
        addr < soc_map_pkg::DRAM_BASE + soc_map_pkg::DRAM_LEN) return soc_map_pkg::TGT_L2;
    if (addr >= soc_map_pkg::UART_BASE &&
        addr < soc_map_pkg::UART_BASE + soc_map_pkg::UART_LEN) return soc_map_pkg::TGT_UART;
    if (addr >= soc_map_pkg::CTRL_BASE &&
        addr < soc_map_pkg::CTRL_BASE + soc_map_pkg::CTRL_LEN) return soc_map_pkg::TGT_CTRL;
    return soc_map_pkg::TGT_NONE;
  endfunction

  soc_map_pkg::target_e             tgt;
  soc_map_pkg::target_e             pend_tgt_q;
  logic                             pend_valid_q;
  logic [soc_map_pkg::ADDR_W-1:0]   base;
  logic [soc_map_pkg::ADDR_W-1:0]   off_full;
  logic                             gnt;
  soc_bus_pkg::tgt_req_t            fwd;
  soc_bus_pkg::bus_rsp_t            pend_rsp;

  //////////////////////////////////////////////////
  // Decode and request steering
  //////////////////////////////////////////////////

  assign tgt = decode(bus_req_i.addr);

  always_comb begin
    case (tgt)
      soc_map_pkg::TGT_L2:   base = soc_map_pkg::DRAM_BASE;
      soc_map_pkg::TGT_UART: base = soc_map_pkg::UART_BASE;
      soc_map_pkg::TGT_CTRL: base = soc_map_pkg::CTRL_BASE;
      default:               base = '0;
    endcase
  end

  assign off_full = bus_req_i.addr - base;

  assign fwd = '{req:    1'b0,
                 we:     bus_req_i.we,
                 offset: off_full[soc_bus_pkg::APB_ADDR_W-1:0],
                 wdata:  bus_req_i.wdata,
                 be:     bus_req_i.be};

  always_comb begin
    l2_req_o       = fwd;
    uart_req_o     = fwd;
    ctrl_req_o     = fwd;
    l2_req_o.req   = bus_req_i.req && (tgt == soc_map_pkg::TGT_L2);
    uart_req_o.req = bus_req_i.req && (tgt == soc_map_pkg::TGT_UART);
    ctrl_req_o.req = bus_req_i.req && (tgt == soc_map_pkg::TGT_CTRL);
  end

  // Grant comes from the addressed target, or at once for a decode miss
  always_comb begin
    case (tgt)
      soc_map_pkg::TGT_L2:   gnt = l2_rsp_i.gnt;
      soc_map_pkg::TGT_UART: gnt = uart_rsp_i.gnt;
      soc_map_pkg::TGT_CTRL: gnt = ctrl_rsp_i.gnt;
      default:               gnt = bus_req_i.req;
    endcase
  end

  //////////////////////////////////////////////////
  // Response routing
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pend_valid_q <= 1'b0;
      pend_tgt_q   <= soc_map_pkg::TGT_NONE;
    end else begin
      pend_valid_q <= gnt;
      if (gnt) pend_tgt_q <= tgt;
    end
  end

  always_comb begin
    case (pend_tgt_q)
      soc_map_pkg::TGT_L2:   pend_rsp = l2_rsp_i;
      soc_map_pkg::TGT_UART: pend_rsp = uart_rsp_i;
      soc_map_pkg::TGT_CTRL: pend_rsp = ctrl_rsp_i;
      // Decode error answered locally
      default: pend_rsp = '{gnt: 1'b0, rvalid: 1'b1, err: 1'b1, rdata: '0};
    endcase
  end

  assign bus_rsp_o = '{gnt:    gnt,
                       rvalid: pend_valid_q && pend_rsp.rvalid,
                       err:    pend_rsp.err,
                       rdata:  pend_rsp.rdata};

  // Targets must not answer outside the slot opened by a grant
  a_rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (l2_rsp_i.rvalid || uart_rsp_i.rvalid || ctrl_rsp_i.rvalid) |-> $past(gnt));

endmodule

// ==== hw/l2_mem.sv ====
// On-chip L2, 64-bit words with byte enables.
// Grants every request at once; read data one cycle later, zero on writes.
`timescale 1ns/1ns

module l2_mem (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  soc_bus_pkg::tgt_req_t req_i,
  output soc_bus_pkg::bus_rsp_t rsp_o
);

  logic [soc_bus_pkg::DATA_W-1:0]   mem [soc_map_pkg::L2_WORDS];
  logic [soc_map_pkg::L2_IDX_W-1:0] idx;
  logic [soc_bus_pkg::DATA_W-1:0]   rdata_q;
  logic                             rvalid_q;

  // Word index from offset bits 12:3, upper bits alias
  assign idx = req_i.offset[soc_map_pkg::L2_IDX_W+2:3];

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      if (req_i.we) begin
        mem[idx] <= soc_bus_pkg::be_merge(mem[idx], req_i.wdata, req_i.be);
        rdata_q  <= '0;
      end else begin
        rdata_q  <= mem[idx];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) rvalid_q <= 1'b0;
    else          rvalid_q <= req_i.req;
  end

  assign rsp_o = '{gnt: req_i.req, rvalid: rvalid_q, err: 1'b0, rdata: rdata_q};

  a_offset_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_i.req |-> !$isunknown(req_i.offset));

endmodule

// ==== hw/uart_apb_bridge.sv ====
// Target port to APB for the UART.
// Only the low 32 data bits travel; APB writes are always full words.
// APB address/data are taken straight from the held request.
`timescale 1ns/1ns

module uart_apb_bridge (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  soc_bus_pkg::tgt_req_t req_i,
  output soc_bus_pkg::bus_rsp_t rsp_o,
  output soc_bus_pkg::apb_req_t apb_req_o,
  input  soc_bus_pkg::apb_rsp_t apb_rsp_i
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,
    ST_ACCESS
  } state_e;

  state_e                         state_q;
  state_e                         state_d;
  logic                           gnt;
  logic                           rvalid_q;
  logic                           err_q;
  logic [soc_bus_pkg::DATA_W-1:0] rdata_q;

  //////////////////////////////////////////////////
  // APB phase FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    gnt     = 1'b0;
    case (state_q)
      ST_IDLE: begin
        if (req_i.req) state_d = ST_SETUP;
      end
      ST_SETUP: state_d = ST_ACCESS;
      ST_ACCESS: begin
        if (apb_rsp_i.pready) begin
          gnt     = 1'b1;
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q  <= ST_IDLE;
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      state_q  <= state_d;
      rvalid_q <= gnt;
      if (gnt) err_q <= apb_rsp_i.pslverr;
    end
  end

  // Read word zero-extended; writes and slave errors return zero
  always_ff @(posedge clk_i) begin
    if (gnt) begin
      rdata_q <= (req_i.we || apb_rsp_i.pslverr) ? '0 :
                 {{(soc_bus_pkg::DATA_W-soc_bus_pkg::APB_DATA_W){1'b0}}, apb_rsp_i.prdata};
    end
  end

  assign apb_req_o = '{psel:    state_q != ST_IDLE,
                       penable: state_q == ST_ACCESS,
                       pwrite:  req_i.we,
                       paddr:   req_i.offset,
                       pwdata:  req_i.wdata[soc_bus_pkg::APB_DATA_W-1:0]};

  assign rsp_o = '{gnt: gnt, rvalid: rvalid_q, err: err_q, rdata: rdata_q};

  // Address, direction and data held through the access phase
  a_apb_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    apb_req_o.penable |-> $stable(apb_req_o.paddr) && $stable(apb_req_o.pwrite) &&
                          $stable(apb_req_o.pwdata));

endmodule

// ==== hw/ctrl_regs.sv ====
// SoC control registers: exit code, counter enable, DRAM bounds.
// DRAM bounds are read-only, writes to them are dropped silently.
// Byte offsets 0x20 and up respond with err.
`timescale 1ns/1ns

module ctrl_regs (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  soc_bus_pkg::tgt_req_t          req_i,
  output soc_bus_pkg::bus_rsp_t          rsp_o,
  output logic [soc_bus_pkg::DATA_W-1:0] exit_o,
  output logic [soc_bus_pkg::DATA_W-1:0] hw_cnt_en_o
);

  soc_map_pkg::ctrl_reg_e         reg_sel;
  logic                           hit;
  logic [soc_bus_pkg::DATA_W-1:0] rd_val;
  logic [soc_bus_pkg::DATA_W-1:0] exit_q;
  logic [soc_bus_pkg::DATA_W-1:0] hw_cnt_en_q;
  logic [soc_bus_pkg::DATA_W-1:0] rdata_q;
  logic                           rvalid_q;
  logic                           err_q;

  assign reg_sel = soc_map_pkg::ctrl_reg_e'(req_i.offset[5:3]);
  assign hit     = (req_i.offset[soc_bus_pkg::APB_ADDR_W-1:5] == '0);

  always_comb begin
    case (reg_sel)
      soc_map_pkg::REG_EXIT:      rd_val = exit_q;
      soc_map_pkg::REG_HW_CNT_EN: rd_val = hw_cnt_en_q;
      soc_map_pkg::REG_DRAM_BASE: rd_val = soc_map_pkg::DRAM_BASE;
      soc_map_pkg::REG_DRAM_END:  rd_val = soc_map_pkg::DRAM_BASE + soc_map_pkg::DRAM_LEN;
      default:                    rd_val = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // Register file
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      exit_q      <= '0;
      hw_cnt_en_q <= '0;
      rvalid_q    <= 1'b0;
      err_q       <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
      if (req_i.req) err_q <= !hit;
      if (req_i.req && req_i.we && hit) begin
        case (reg_sel)
          soc_map_pkg::REG_EXIT:
            exit_q <= soc_bus_pkg::be_merge(exit_q, req_i.wdata, req_i.be);
          soc_map_pkg::REG_HW_CNT_EN:
            hw_cnt_en_q <= soc_bus_pkg::be_merge(hw_cnt_en_q, req_i.wdata, req_i.be);
          default: ;
        endcase
      end
    end
  end

  // Zero data on writes and on misses
  always_ff @(posedge clk_i) begin
    if (req_i.req) rdata_q <= (req_i.we || !hit) ? '0 : rd_val;
  end

  assign rsp_o       = '{gnt: req_i.req, rvalid: rvalid_q, err: err_q, rdata: rdata_q};
  assign exit_o      = exit_q;
  assign hw_cnt_en_o = hw_cnt_en_q;

endmodule

// ==== hw/soc_top.sv ====
// SoC interconnect top: one bus master port, L2, UART over APB, control registers.
// The UART itself sits outside; only its APB port is exposed.
`timescale 1ns/1ns

module soc_top (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  soc_bus_pkg::bus_req_t          bus_req_i,
  output soc_bus_pkg::bus_rsp_t          bus_rsp_o,
  output soc_bus_pkg::apb_req_t          apb_req_o,
  input  soc_bus_pkg::apb_rsp_t          apb_rsp_i,
  output logic [soc_bus_pkg::DATA_W-1:0] exit_o,
  output logic [soc_bus_pkg::DATA_W-1:0] hw_cnt_en_o
);

  soc_bus_pkg::tgt_req_t l2_req;
  soc_bus_pkg::tgt_req_t uart_req;
  soc_bus_pkg::tgt_req_t ctrl_req;
  soc_bus_pkg::bus_rsp_t l2_rsp;
  soc_bus_pkg::bus_rsp_t uart_rsp;
  soc_bus_pkg::bus_rsp_t ctrl_rsp;

  soc_xbar i_soc_xbar (
    .clk_i      (clk_i    ),
    .rst_n_i    (rst_n_i  ),
    .bus_req_i  (bus_req_i),
    .bus_rsp_o  (bus_rsp_o),
    .l2_req_o   (l2_req   ),
    .uart_req_o (uart_req ),
    .ctrl_req_o (ctrl_req ),
    .l2_rsp_i   (l2_rsp   ),
    .uart_rsp_i (uart_rsp ),
    .ctrl_rsp_i (ctrl_rsp )
  );

  l2_mem i_l2_mem (
    .clk_i   (clk_i  ),
    .rst_n_i (rst_n_i),
    .req_i   (l2_req ),
    .rsp_o   (l2_rsp )
  );

  uart_apb_bridge i_uart_apb_bridge (
    .clk_i     (clk_i    ),
    .rst_n_i   (rst_n_i  ),
    .req_i     (uart_req ),
    .rsp_o     (uart_rsp ),
    .apb_req_o (apb_req_o),
    .apb_rsp_i (apb_rsp_i)
  );

  ctrl_regs i_ctrl_regs (
    .clk_i       (clk_i      ),
    .rst_n_i     (rst_n_i    ),
    .req_i       (ctrl_req   ),
    .rsp_o       (ctrl_rsp   ),
    .exit_o      (exit_o     ),
    .hw_cnt_en_o (hw_cnt_en_o)
  );

endmodule

// ==== verif/tb_soc_top.sv ====
// Testbench for soc_top, acting as the only bus master.
// Random traffic from a fixed seed is checked against a reference model of L2,
// the control registers and the APB slave model below.
// The first 16 transactions fill the L2 words that later reads use.
`timescale 1ns/1ns

module tb_soc_top;

  localparam int CLK_PERIOD = 100;
  localparam int N_TXN      = 2000;
  localparam int L2_FILL    = 16;
  localparam int TIMEOUT_NS = N_TXN * 10 * CLK_PERIOD;

  // Test index, also the region code from region_of
  localparam int T_TIMING = 0;
  localparam int T_L2     = 1;
  localparam int T_CTRL   = 2;
  localparam int T_UART   = 3;
  localparam int T_NONE   = 4;

  typedef struct packed {
    logic [2:0]  test;
    logic        err;
    logic [63:0] rdata;
  } expect_t;

  logic                  clk_i     = 1'b0;
  logic                  rst_n_i   = 1'b0;
  soc_bus_pkg::bus_req_t bus_req_i = '0;
  soc_bus_pkg::bus_rsp_t bus_rsp_o;
  soc_bus_pkg::apb_req_t apb_req_o;
  soc_bus_pkg::apb_rsp_t apb_rsp_i = '0;
  logic [63:0]           exit_o;
  logic [63:0]           hw_cnt_en_o;

  integer      seed          = 32'hb9ce29dd;
  int          apb_wait_pick = 0;
  int          chk_cnt [5];
  int          err_cnt [5];
  expect_t     exp_q [$];
  logic [63:0] l2_ref [soc_map_pkg::L2_WORDS];
  logic [31:0] uart_ref [8];
  logic [31:0] apb_mem [8];
  logic [63:0] exit_ref;
  logic [63:0] cnt_ref;

  soc_top UUT (
    .clk_i       (clk_i      ),
    .rst_n_i     (rst_n_i    ),
    .bus_req_i   (bus_req_i  ),
    .bus_rsp_o   (bus_rsp_o  ),
    .apb_req_o   (apb_req_o  ),
    .apb_rsp_i   (apb_rsp_i  ),
    .exit_o      (exit_o     ),
    .hw_cnt_en_o (hw_cnt_en_o)
  );

  initial begin
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  function automatic logic [31:0] next_rand();
    return $random(seed);
  endfunction

  function automatic logic [31:0] word_pattern(input int i);
    return 32'hA5C3_0000 ^ (32'(i) * 32'h0101_0101);
  endfunction

  function automatic int region_of(input logic [63:0] a);
    if (a >= soc_map_pkg::DRAM_BASE && a < soc_map_pkg::DRAM_BASE + soc_map_pkg::DRAM_LEN)
      return T_L2;
    if (a >= soc_map_pkg::UART_BASE && a < soc_map_pkg::UART_BASE + soc_map_pkg::UART_LEN)
      return T_UART;
    if (a >= soc_map_pkg::CTRL_BASE && a < soc_map_pkg::CTRL_BASE + soc_map_pkg::CTRL_LEN)
      return T_CTRL;
    return T_NONE;
  endfunction

  function automatic logic [63:0] apply_byte_enables(input logic [63:0] old_d,
                                                     input logic [63:0] new_d,
                                                     input logic [7:0]  be);
    logic [63:0] mask;
    for (int b = 0; b < 8; b++) begin
      mask[b*8 +: 8] = {8{be[b]}};
    end
    return (old_d & ~mask) | (new_d & mask);
  endfunction

  task automatic compare(input int t, input string name,
                         input logic [63:0] exp, input logic [63:0] act);
    chk_cnt[t]++;
    assert (act === exp) else begin
      err_cnt[t]++;
      $display("[FAIL] %0t ns %s: expected %h, actual %h", $time, name, exp, act);
    end
  endtask

  task automatic confirm(input int t, input logic cond, input string what);
    chk_cnt[t]++;
    assert (cond) else begin
      err_cnt[t]++;
      $display("%0t ns: %s", $time, what);
    end
  endtask

  ////////////////////////////////////////////////////
  // Stimulus and reference model
  ////////////////////////////////////////////////////

  task automatic make_request(input int n, output soc_bus_pkg::bus_req_t r, output int waits);
    logic [31:0] tmp;
    int          region;
    tmp     = next_rand();
    region  = int'(tmp % 4) + 1;
    r.req   = 1'b1;
    r.we    = tmp[4];
    r.be    = tmp[15:8];
    waits   = int'(tmp[17:16]);
    r.wdata = {next_rand(), next_rand()};
    tmp     = next_rand();
    if (n < L2_FILL) begin
      r.we   = 1'b1;
      r.be   = 8'hFF;
      r.addr = soc_map_pkg::DRAM_BASE + {57'b0, 4'(n), 3'b000};
    end else begin
      case (region)
        // Random upper bits exercise aliasing onto 16 words
        T_L2: r.addr = soc_map_pkg::DRAM_BASE + {32'b0, tmp & 32'h3FFF_E000} +
                       {57'b0, tmp[3:0], 3'b000};
        T_UART: r.addr = soc_map_pkg::UART_BASE + {58'b0, 4'(tmp % 12), 2'b00};
        T_CTRL: r.addr = soc_map_pkg::CTRL_BASE + {58'b0, 3'(tmp % 6), 3'b000};
        default: begin
          if (tmp[0]) r.addr = {24'h000001, next_rand(), 8'h00};
          else r.addr = soc_map_pkg::UART_BASE + soc_map_pkg::UART_LEN + {52'b0, tmp[11:3], 3'b0};
        end
      endcase
    end
  endtask

  task automatic predict(input soc_bus_pkg::bus_req_t r);
    expect_t     e;
    logic [63:0] off;
    int          region;
    region  = region_of(r.addr);
    e.test  = 3'(region);
    e.err   = 1'b0;
    e.rdata = '0;
    case (region)
      T_L2: begin
        off = r.addr - soc_map_pkg::DRAM_BASE;
        if (r.we) l2_ref[off[12:3]] = apply_byte_enables(l2_ref[off[12:3]], r.wdata, r.be);
        else e.rdata = l2_ref[off[12:3]];
      end
      T_UART: begin
        off = r.addr - soc_map_pkg::UART_BASE;
        if (off >= 64'h20) e.err = 1'b1;
        else if (r.we) uart_ref[off[4:2]] = r.wdata[31:0];
        else e.rdata = {32'b0, uart_ref[off[4:2]]};
      end
      T_CTRL: begin
        off = r.addr - soc_map_pkg::CTRL_BASE;
        if (off >= 64'h20) begin
          e.err = 1'b1;
        end else if (off[4:3] == 2'd0) begin
          if (r.we) exit_ref = apply_byte_enables(exit_ref, r.wdata, r.be);
          else e.rdata = exit_ref;
        end else if (off[4:3] == 2'd1) begin
          if (r.we) cnt_ref = apply_byte_enables(cnt_ref, r.wdata, r.be);
          else e.rdata = cnt_ref;
        end else if (!r.we) begin
          e.rdata = (off[4:3] == 2'd2) ? 64'h8000_0000 : 64'hC000_0000;
        end
      end
      default: e.err = 1'b1;
    endcase
    exp_q.push_back(e);
  endtask

  // APB slave, 0 to 3 wait cycles chosen by the master per request
  // Error responses still carry a data word
  always @(posedge clk_i) begin
    int wait_left;
    if (!rst_n_i) begin
      apb_rsp_i <= '0;
      wait_left = 0;
      for (int i = 0; i < 8; i++) apb_mem[i] <= word_pattern(i);
    end else if (apb_req_o.psel && apb_req_o.penable && apb_rsp_i.pready) begin
      if (apb_req_o.pwrite && !apb_rsp_i.pslverr) begin
        apb_mem[apb_req_o.paddr[4:2]] <= apb_req_o.pwdata;
      end
      apb_rsp_i <= '0;
    end else if (apb_req_o.psel) begin
      if (!apb_req_o.penable) wait_left = apb_wait_pick;
      else wait_left = wait_left - 1;
      if (wait_left == 0) begin
        apb_rsp_i.pready  <= 1'b1;
        apb_rsp_i.pslverr <= apb_req_o.paddr >= 32'h20;
        apb_rsp_i.prdata  <= apb_mem[apb_req_o.paddr[4:2]];
      end
    end
  end

  ////////////////////////////////////////////////////
  // Monitor, sampled at the rising edge
  ////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    expect_t e;
    logic    gnt_seen_q;
    logic    setup_q;
    logic    running_q;
    int      setup_cnt;
    int      req_wait;
    if (!rst_n_i) begin
      gnt_seen_q = 1'b0;
      setup_q    = 1'b0;
      running_q  = 1'b0;
      setup_cnt  = 0;
      req_wait   = 0;
      exit_ref   = '0;
      cnt_ref    = '0;
      for (int i = 0; i < 8; i++) uart_ref[i] = word_pattern(i);
    end else begin
      if (!running_q) begin
        compare(T_TIMING, "exit_o", 64'd0, exit_o);
        compare(T_TIMING, "hw_cnt_en_o", 64'd0, hw_cnt_en_o);
        compare(T_TIMING, "psel", 64'd0, 64'(apb_req_o.psel));
        running_q = 1'b1;
      end
      compare(T_TIMING, "rvalid", 64'(gnt_seen_q), 64'(bus_rsp_o.rvalid));
      if (bus_rsp_o.rvalid && exp_q.size() > 0) begin
        e = exp_q.pop_front();
        compare(int'(e.test), "err", 64'(e.err), 64'(bus_rsp_o.err));
        compare(int'(e.test), "rdata", e.rdata, bus_rsp_o.rdata);
        if (int'(e.test) == T_CTRL) begin
          compare(T_CTRL, "exit_o", exit_ref, exit_o);
          compare(T_CTRL, "hw_cnt_en_o", cnt_ref, hw_cnt_en_o);
        end
      end
      // One setup cycle, then penable
      if (setup_q) compare(T_UART, "penable", 64'd1, 64'(apb_req_o.penable));
      setup_q = apb_req_o.psel && !apb_req_o.penable;
      if (setup_q) begin
        setup_cnt++;
        confirm(T_UART, bus_req_i.req && region_of(bus_req_i.addr) == T_UART,
                "APB setup phase seen without a UART request");
        compare(T_UART, "paddr", bus_req_i.addr - soc_map_pkg::UART_BASE, 64'(apb_req_o.paddr));
        compare(T_UART, "pwdata", 64'(bus_req_i.wdata[31:0]), 64'(apb_req_o.pwdata));
        compare(T_UART, "pwrite", 64'(bus_req_i.we), 64'(apb_req_o.pwrite));
      end
      if (bus_req_i.req && !bus_rsp_o.gnt) req_wait++;
      if (bus_rsp_o.gnt) begin
        confirm(T_TIMING, bus_req_i.req, "grant seen with no request");
        if (region_of(bus_req_i.addr) == T_UART) begin
          compare(T_UART, "setup cycles", 64'd1, 64'(setup_cnt));
          setup_cnt = 0;
        end else begin
          compare(region_of(bus_req_i.addr), "grant wait", 64'd0, 64'(req_wait));
        end
        req_wait = 0;
        predict(bus_req_i);
      end
      gnt_seen_q = bus_rsp_o.gnt;
    end
  end

  initial begin
    soc_bus_pkg::bus_req_t r;
    logic [31:0]           gap;
    int                    waits;
    int                    total_chk;
    int                    total_err;
    string                 test_name [5];
    test_name[T_TIMING] = "reset and response timing";
    test_name[T_L2]     = "L2 byte-enabled access";
    test_name[T_CTRL]   = "control registers";
    test_name[T_UART]   = "UART over APB";
    test_name[T_NONE]   = "unmapped addresses";
    total_chk = 0;
    total_err = 0;
    repeat (10) @(posedge clk_i);
    rst_n_i <= 1'b1;
    for (int n = 0; n < N_TXN; n++) begin
      gap = next_rand();
      if (n >= L2_FILL && gap[2:0] == 3'd0) begin
        bus_req_i <= '0;
        @(posedge clk_i);
      end
      make_request(n, r, waits);
      bus_req_i     <= r;
      apb_wait_pick <= waits;
      @(posedge clk_i);
      while (!bus_rsp_o.gnt) @(posedge clk_i);
    end
    bus_req_i <= '0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    assert (exp_q.size() == 0) else begin
      $display("%0d responses never arrived", exp_q.size());
      total_err++;
    end
    for (int t = 0; t < 5; t++) begin
      $display("test %0d, %s: %0d checks, %0d errors", t + 1, test_name[t], chk_cnt[t],
               err_cnt[t]);
      total_chk += chk_cnt[t];
      total_err += err_cnt[t];
    end
    $display("Total: %0d checks passed, %0d failed", total_chk - total_err, total_err);
    if (total_err == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: bus traffic did not finish within %0d ns", TIMEOUT_NS);
    $display("Test failed");
    $finish;
  end

endmodule

// ==== list.f ====
hw/soc_map_pkg.sv
hw/soc_bus_pkg.sv
hw/soc_xbar.sv
hw/l2_mem.sv
hw/uart_apb_bridge.sv
hw/ctrl_regs.sv
hw/soc_top.sv
verif/tb_soc_top.sv

// ==== Makefile ====
# Verilator build and run for the SoC interconnect testbench

VERILATOR ?= verilator
TOP       ?= tb_soc_top
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Test failed" $(LOG); then \
	  echo "Simulation reported a failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
